// ==== hdl/mem_bus_pkg.sv ====
/*
  Memory bus definitions for the fetch front end.
  A response or reply tag of zero means no tag. One bus word is one cache line.
  BUS_STORE exists for the bus encoding and is never issued by fetch.
*/

`default_nettype none

package mem_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int MEM_TAG_W  = 4;   // Response and reply tags
  localparam int MEM_DATA_W = 64;  // One line per transfer

  typedef logic [MEM_TAG_W-1:0]  mem_tag_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;

  // Command sent with each request
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
/*
  Fetch geometry and instruction definitions.
  Direct-mapped cache of 128 lines, 8 bytes each, two instructions per line.
  Addresses are 32 bits and split as tag, index, byte offset.
*/

`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // Address and instruction
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int INST_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INST_W-1:0] inst_t;

  // Alpha no-op, used as the bubble word in IF/ID
  localparam inst_t NOOP_INST = 32'h47ff_041f;

  ////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////

  localparam int OFFSET_W  = 3;                          // Byte within line
  localparam int INDEX_W   = 7;
  localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W; // 22 bits
  localparam int NUM_LINES = 2 ** INDEX_W;

  typedef logic [INDEX_W-1:0] cache_index_t;
  typedef logic [TAG_W-1:0]   cache_tag_t;

endpackage

`default_nettype wire

// ==== hdl/icache_mem.sv ====
/*
  Storage for the direct-mapped instruction cache.
  Reads are combinational, the write takes effect at the clock edge.
  Only the valid bits are cleared by reset.
*/

`timescale 1ns/1ps
`default_nettype none

module icache_mem (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   wr_en,
  input  fetch_pkg::cache_index_t wr_idx,
  input  fetch_pkg::cache_tag_t   wr_tag,
  input  mem_bus_pkg::mem_data_t  wr_data,
  input  fetch_pkg::cache_index_t rd_idx,
  input  fetch_pkg::cache_tag_t   rd_tag,
  output mem_bus_pkg::mem_data_t  rd_data,
  output logic                   rd_valid
);

  import fetch_pkg::*;
  import mem_bus_pkg::*;

  mem_data_t            data_mem [NUM_LINES];
  cache_tag_t           tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0] valid_bits;

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      valid_bits <= '0;            // Every line invalid
    end
    else if (wr_en)
    begin
      valid_bits[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);  // Hit

endmodule

`default_nettype wire

// ==== hdl/icache_ctrl.sv ====
/*
  Instruction cache controller with a single outstanding miss.
  A miss requests its line in the same cycle, a refused request is retried
  every cycle. The fill is written under the index and tag recorded at accept,
  even if fetch has moved on. The bus stays idle in the first cycle out of reset.
*/

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                    clock,
  input  logic                    rst,
  input  fetch_pkg::addr_t        fetch_addr,
  input  mem_bus_pkg::mem_tag_t   mem2proc_response,
  input  mem_bus_pkg::mem_tag_t   mem2proc_tag,
  input  mem_bus_pkg::mem_data_t  mem2proc_data,
  input  mem_bus_pkg::mem_data_t  rd_data,
  input  logic                    rd_valid,
  output mem_bus_pkg::mem_data_t  fetch_inst_line,
  output logic                    fetch_hit,
  output mem_bus_pkg::bus_cmd_t   proc2mem_command,
  output fetch_pkg::addr_t        proc2mem_addr,
  output fetch_pkg::cache_index_t rd_idx,
  output fetch_pkg::cache_tag_t   rd_tag,
  output logic                    wr_en,
  output fetch_pkg::cache_index_t wr_idx,
  output fetch_pkg::cache_tag_t   wr_tag,
  output mem_bus_pkg::mem_data_t  wr_data
);

  import fetch_pkg::*;
  import mem_bus_pkg::*;

  mem_tag_t     miss_tag;      // Accepted tag, zero when idle
  cache_index_t miss_idx;
  cache_tag_t   miss_ctag;
  logic         bus_armed;     // Low for one cycle after reset
  logic         miss_pending;
  logic         issue_load;
  logic         req_accepted;
  logic         fill_match;

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  assign rd_idx = fetch_addr[OFFSET_W +: INDEX_W];
  assign rd_tag = fetch_addr[OFFSET_W + INDEX_W +: TAG_W];

  assign fetch_inst_line = rd_data;
  assign fetch_hit       = rd_valid;

  ////////////////////////////////////////////////////////////
  // Request and fill
  ////////////////////////////////////////////////////////////

  assign miss_pending = (miss_tag != '0);
  assign issue_load   = bus_armed && !rd_valid && !miss_pending;
  assign req_accepted = issue_load && (mem2proc_response != '0);
  assign fill_match   = miss_pending && (mem2proc_tag == miss_tag);

  assign proc2mem_command = issue_load ? BUS_LOAD : BUS_NONE;
  // Line aligned address
  assign proc2mem_addr    = {fetch_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // Fill goes to the line recorded at accept
  assign wr_en   = fill_match;
  assign wr_idx  = miss_idx;
  assign wr_tag  = miss_ctag;
  assign wr_data = mem2proc_data;

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      miss_tag  <= '0;
      bus_armed <= 1'b0;
    end
    else
    begin
      bus_armed <= 1'b1;
      if (fill_match)
      begin
        miss_tag <= '0;                 // Line written, miss done
      end
      else if (req_accepted)
      begin
        miss_tag <= mem2proc_response;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (req_accepted)
    begin
      miss_idx  <= rd_idx;
      miss_ctag <= rd_tag;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/if_stage.sv ====
/*
  Program counter and IF/ID register of a scalar fetch stage.
  Redirect wins over stall and flushes IF/ID to a no-op bubble.
  On a miss the PC holds and a bubble enters IF/ID.
*/

`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   redirect,
  input  fetch_pkg::addr_t       redirect_pc,
  input  mem_bus_pkg::mem_data_t fetch_inst_line,
  input  logic                   fetch_hit,
  output fetch_pkg::addr_t       fetch_addr,
  output fetch_pkg::addr_t       if_id_npc,
  output fetch_pkg::inst_t       if_id_ir,
  output logic                   if_id_valid
);

  import fetch_pkg::*;

  addr_t pc;
  addr_t pc_plus4;
  inst_t fetch_inst;

  ////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////

  assign fetch_addr = pc;
  assign pc_plus4   = pc + ADDR_W'(4);

  // Address bit 2 picks the upper word
  assign fetch_inst = pc[2] ? fetch_inst_line[2*INST_W-1:INST_W]
                            : fetch_inst_line[INST_W-1:0];

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      pc <= '0;
    end
    else if (redirect)
    begin
      pc <= redirect_pc;
    end
    else if (!stall && fetch_hit)
    begin
      pc <= pc_plus4;               // Advance only on a hit
    end
  end

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst || redirect)
    begin
      if_id_npc   <= '0;
      if_id_ir    <= NOOP_INST;
      if_id_valid <= 1'b0;
    end
    else if (!stall)
    begin
      if_id_npc   <= pc_plus4;
      if_id_ir    <= fetch_hit ? fetch_inst : NOOP_INST;  // Bubble on a miss
      if_id_valid <= fetch_hit;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
/*
  Instruction fetch front end.
  Stall stands in for the dispatch hazard, redirect for the mispredict target.
  The memory port carries instruction loads only.
*/

`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   redirect,
  input  fetch_pkg::addr_t       redirect_pc,
  input  mem_bus_pkg::mem_tag_t  mem2proc_response,
  input  mem_bus_pkg::mem_data_t mem2proc_data,
  input  mem_bus_pkg::mem_tag_t  mem2proc_tag,
  output mem_bus_pkg::bus_cmd_t  proc2mem_command,
  output fetch_pkg::addr_t       proc2mem_addr,
  output fetch_pkg::addr_t       if_id_npc,
  output fetch_pkg::inst_t       if_id_ir,
  output logic                   if_id_valid
);

  import fetch_pkg::*;
  import mem_bus_pkg::*;

  addr_t        fetch_addr;
  mem_data_t    fetch_inst_line;
  logic         fetch_hit;

  // Cache array ports
  cache_index_t rd_idx;
  cache_tag_t   rd_tag;
  mem_data_t    rd_data;
  logic         rd_valid;
  logic         wr_en;
  cache_index_t wr_idx;
  cache_tag_t   wr_tag;
  mem_data_t    wr_data;

  ////////////////////////////////////////////////////////////
  // Fetch stage
  ////////////////////////////////////////////////////////////

  if_stage if_stage_0 (
    .clock           (clock),
    .rst             (rst),
    .stall           (stall),
    .redirect        (redirect),
    .redirect_pc     (redirect_pc),
    .fetch_inst_line (fetch_inst_line),
    .fetch_hit       (fetch_hit),
    .fetch_addr      (fetch_addr),
    .if_id_npc       (if_id_npc),
    .if_id_ir        (if_id_ir),
    .if_id_valid     (if_id_valid)
  );

  ////////////////////////////////////////////////////////////
  // Instruction cache
  ////////////////////////////////////////////////////////////

  icache_ctrl icache_ctrl_0 (
    .clock             (clock),
    .rst               (rst),
    .fetch_addr        (fetch_addr),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .rd_data           (rd_data),
    .rd_valid          (rd_valid),
    .fetch_inst_line   (fetch_inst_line),
    .fetch_hit         (fetch_hit),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .rd_idx            (rd_idx),
    .rd_tag            (rd_tag),
    .wr_en             (wr_en),
    .wr_idx            (wr_idx),
    .wr_tag            (wr_tag),
    .wr_data           (wr_data)
  );

  icache_mem icache_mem_0 (
    .clock    (clock),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_idx   (wr_idx),
    .wr_tag   (wr_tag),
    .wr_data  (wr_data),
    .rd_idx   (rd_idx),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
/*
  Free running testbench clock and a reset held for two rising edges.
  Reset is released 1 ns after the second edge, like every other input.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 100  // ns
) (
  output logic clock,
  output logic rst
);

  initial
  begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clock);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/fetch_checker.sv ====
/*
  Concurrent assertions on the fetch front end, bound into fetch_top.
  Covers the command encoding, line alignment of loads, IF/ID hold
  under stall and an idle bus in the first cycle after reset.
*/

`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
  input logic                  clock,
  input logic                  rst,
  input logic                  stall,
  input logic                  redirect,
  input mem_bus_pkg::bus_cmd_t proc2mem_command,
  input fetch_pkg::addr_t      proc2mem_addr,
  input fetch_pkg::addr_t      if_id_npc,
  input fetch_pkg::inst_t      if_id_ir,
  input logic                  if_id_valid
);

  import mem_bus_pkg::*;

  logic fail_seen = 1'b0;  // Any assertion below has failed

  cmd_legal: assert property (@(posedge clock) disable iff (rst)
    proc2mem_command inside {BUS_NONE, BUS_LOAD})
    else
    begin
      $error("Bus command %0d is neither none nor load", proc2mem_command);
      fail_seen = 1'b1;
    end

  load_aligned: assert property (@(posedge clock) disable iff (rst)
    (proc2mem_command == BUS_LOAD) |-> (proc2mem_addr[2:0] == 3'b000))
    else
    begin
      $error("Load address %h is not line aligned", proc2mem_addr);
      fail_seen = 1'b1;
    end

  // Redirect wins over stall, so only a plain stall must hold IF/ID
  stall_hold: assert property (@(posedge clock) disable iff (rst)
    (stall && !redirect) |=>
      ($stable(if_id_npc) && $stable(if_id_ir) && $stable(if_id_valid)))
    else
    begin
      $error("IF/ID changed during a stall");
      fail_seen = 1'b1;
    end

  idle_after_reset: assert property (@(posedge clock)
    $fell(rst) |-> (proc2mem_command == BUS_NONE))
    else
    begin
      $error("Bus command was not idle in the first cycle after reset");
      fail_seen = 1'b1;
    end

endmodule

bind fetch_top fetch_checker fetch_checker_0 (
  .clock            (clock),
  .rst              (rst),
  .stall            (stall),
  .redirect         (redirect),
  .proc2mem_command (proc2mem_command),
  .proc2mem_addr    (proc2mem_addr),
  .if_id_npc        (if_id_npc),
  .if_id_ir         (if_id_ir),
  .if_id_valid      (if_id_valid)
);

`default_nettype wire

// ==== test/fetch_tb.sv ====
/*
  Testbench for the fetch front end.
  Memory refuses about one request in four and replies 1 to 4 cycles after
  accept. The word at byte address a is a xor 32'hA5A5_0000.
  Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge.
*/

`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  import mem_bus_pkg::*;
  import fetch_pkg::*;

  typedef struct packed {
    logic        stall;
    logic        redirect;
    addr_t       target;
    logic [15:0] cycles;
  } row_t;

  localparam int    ROWS       = 15;
  localparam int    PERIOD     = 100;
  localparam int    MISS_WORST = 8;    // Cycles per table cycle, worst case
  localparam int    MARGIN     = 200;
  localparam inst_t WORD_KEY   = 32'hA5A5_0000;

  // stall, redirect, target, cycles
  localparam row_t STIM [ROWS] = '{
    '{1'b0, 1'b0, 32'h0000_0000, 16'd120},  // Cold stream from reset
    '{1'b0, 1'b1, 32'h0000_0010, 16'd1},
    '{1'b0, 1'b0, 32'h0000_0000, 16'd12},   // Second pass, lines cached
    '{1'b1, 1'b0, 32'h0000_0000, 16'd5},
    '{1'b0, 1'b0, 32'h0000_0000, 16'd10},
    '{1'b1, 1'b1, 32'h0000_0400, 16'd1},    // Redirect beats stall
    '{1'b0, 1'b0, 32'h0000_0000, 16'd40},   // Aliases the first lines
    '{1'b1, 1'b0, 32'h0000_0000, 16'd3},
    '{1'b0, 1'b0, 32'h0000_0000, 16'd20},
    '{1'b0, 1'b1, 32'h0000_01fc, 16'd1},    // Upper word of a line
    '{1'b0, 1'b0, 32'h0000_0000, 16'd25},
    '{1'b1, 1'b0, 32'h0000_0000, 16'd1},
    '{1'b0, 1'b0, 32'h0000_0000, 16'd2},
    '{1'b0, 1'b1, 32'h0000_0020, 16'd2},    // Back to back redirects
    '{1'b0, 1'b0, 32'h0000_0000, 16'd4}
  };

  logic       clock;
  logic       rst;
  logic       stall;
  logic       redirect;
  addr_t      redirect_pc;
  mem_tag_t   mem2proc_response;
  mem_tag_t   mem2proc_tag;
  mem_data_t  mem2proc_data;
  bus_cmd_t   proc2mem_command;
  addr_t      proc2mem_addr;
  addr_t      if_id_npc;
  inst_t      if_id_ir;
  logic       if_id_valid;

  // Memory model and reference state
  integer     seed = 32'h47bd;
  mem_tag_t   next_tag = 4'd1;
  logic       reply_busy = 1'b0;
  mem_tag_t   reply_tag;
  addr_t      reply_addr;
  int         reply_wait;
  logic       line_valid [NUM_LINES];
  cache_tag_t line_tag [NUM_LINES];
  addr_t      exp_pc;
  logic       prev_stall;
  logic       prev_redirect;
  addr_t      prev_target;
  addr_t      held_npc;
  inst_t      held_ir;
  logic       held_valid;
  logic       fetched_since_redirect = 1'b0;
  int         fetch_count = 0;
  int         load_count = 0;
  int         refuse_count = 0;

  tb_clock_gen #(.PERIOD(PERIOD)) clock_gen (.clock(clock), .rst(rst));

  fetch_top uut (
    .clock             (clock),
    .rst               (rst),
    .stall             (stall),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .if_id_npc         (if_id_npc),
    .if_id_ir          (if_id_ir),
    .if_id_valid       (if_id_valid)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
      stop_on_error($sformatf("Error at %0d ns: %s is %0h, expected %0h",
                              $time, name, actual, expected));
  endtask

  // Lower word at the line address, upper word 4 bytes above
  function automatic mem_data_t line_word(input addr_t line_addr);
    return {(line_addr + 32'd4) ^ WORD_KEY, line_addr ^ WORD_KEY};
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  initial
  begin
    mem2proc_response = '0;
    mem2proc_tag      = '0;
    mem2proc_data     = '0;
    forever
    begin
      @(posedge clock);
      #1;
      mem2proc_tag  = '0;
      mem2proc_data = '0;
      if (reply_busy && reply_wait == 0)
      begin
        mem2proc_tag  = reply_tag;
        mem2proc_data = line_word(reply_addr);
      end
      else if (reply_busy)
        reply_wait = reply_wait - 1;
      // Offered every cycle, counts only with a load
      if ($unsigned($random(seed)) % 4 == 0)
        mem2proc_response = '0;
      else
        mem2proc_response = next_tag;
    end
  end

  task automatic watch_bus();
    cache_index_t idx;
    cache_tag_t   ctag;
    if (reply_busy && mem2proc_tag == reply_tag)
    begin
      idx             = reply_addr[OFFSET_W +: INDEX_W];
      line_valid[idx] = 1'b1;
      line_tag[idx]   = reply_addr[OFFSET_W + INDEX_W +: TAG_W];
      reply_busy      = 1'b0;  // Fill lands at the next edge
    end
    if (proc2mem_command == BUS_LOAD)
    begin
      idx  = proc2mem_addr[OFFSET_W +: INDEX_W];
      ctag = proc2mem_addr[OFFSET_W + INDEX_W +: TAG_W];
      check_value("proc2mem_addr[2:0]", proc2mem_addr[2:0], 3'b000);
      if (reply_busy)
        stop_on_error("A load was issued while another miss was outstanding");
      if (line_valid[idx] && line_tag[idx] == ctag)
        stop_on_error($sformatf("A load was issued for cached line %h", proc2mem_addr));
      if (mem2proc_response != '0)
      begin
        reply_busy = 1'b1;
        reply_tag  = mem2proc_response;
        reply_addr = proc2mem_addr;
        reply_wait = $unsigned($random(seed)) % 4;
        next_tag   = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        load_count++;
      end
      else
        refuse_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model of the IF/ID stream
  ////////////////////////////////////////////////////////////

  task automatic check_if_id();
    if (prev_redirect)
    begin
      check_value("if_id_valid", if_id_valid, 1'b0);
      check_value("if_id_ir", if_id_ir, NOOP_INST);
      check_value("if_id_npc", if_id_npc, '0);
      exp_pc                 = prev_target;
      fetched_since_redirect = 1'b0;
    end
    else if (prev_stall)
    begin
      check_value("if_id_valid", if_id_valid, held_valid);
      check_value("if_id_ir", if_id_ir, held_ir);
      check_value("if_id_npc", if_id_npc, held_npc);
    end
    else if (if_id_valid)
    begin
      check_value("if_id_npc", if_id_npc, exp_pc + 32'd4);
      check_value("if_id_ir", if_id_ir, exp_pc ^ WORD_KEY);
      exp_pc                 = exp_pc + 32'd4;
      fetched_since_redirect = 1'b1;
      fetch_count++;
    end
  endtask

  always @(negedge clock)
  begin
    if (rst)
    begin
      exp_pc     = '0;
      reply_busy = 1'b0;
      next_tag   = 4'd1;
      for (int i = 0; i < NUM_LINES; i++)
        line_valid[i] = 1'b0;
    end
    else
    begin
      watch_bus();
      check_if_id();
      if (uut.fetch_checker_0.fail_seen)
        stop_on_error("An assertion in the bound checker failed");
    end
    held_npc      = if_id_npc;
    held_ir       = if_id_ir;
    held_valid    = if_id_valid;
    prev_stall    = rst ? 1'b0 : stall;   // Inputs that the next edge uses
    prev_redirect = rst ? 1'b0 : redirect;
    prev_target   = redirect_pc;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    @(negedge rst);
    for (int r = 0; r < ROWS; r++)
    begin
      for (int c = 0; c < STIM[r].cycles; c++)
      begin
        stall       = STIM[r].stall;
        redirect    = STIM[r].redirect;
        redirect_pc = STIM[r].target;
        @(posedge clock);
        #1;
      end
    end
    stall    = 1'b0;
    redirect = 1'b0;
    // Stream has to resume and the last fill has to land
    while (!fetched_since_redirect || reply_busy)
    begin
      @(posedge clock);
      #1;
    end
    $display("Fetched %0d instructions, %0d loads accepted, %0d refused",
             fetch_count, load_count, refuse_count);
    if (!uut.fetch_checker_0.fail_seen)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
    begin
      $display(">>> FAIL");
      $fatal(1, "An assertion in the bound checker failed");
    end
  end

  initial
  begin
    int limit;
    limit = MARGIN;
    for (int r = 0; r < ROWS; r++)
      limit += STIM[r].cycles * MISS_WORST;
    #(limit * PERIOD);
    stop_on_error($sformatf("Timeout: the run did not finish within %0d cycles", limit));
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/mem_bus_pkg.sv
hdl/fetch_pkg.sv
hdl/icache_mem.sv
hdl/icache_ctrl.sv
hdl/if_stage.sv
hdl/fetch_top.sv
test/tb_clock_gen.sv
test/fetch_checker.sv
test/fetch_tb.sv
